//--- aes_ctrl.f
+incdir+include
src/aes_ctrl_pkg.sv
src/block_packer.sv
src/aes_ctrl_fsm.sv
src/aes_enc_core.sv
src/cbc_chain.sv
src/block_unpacker.sv
src/aes_ctrl_top.sv
verification/aes_ctrl_sva.sv
verification/aes_ctrl_tb.sv

//--- include/aes_ctrl_cfg.svh
`ifndef AES_CTRL_CFG_SVH
`define AES_CTRL_CFG_SVH

// Bus word and block widths
`define AES_WORD_W 32
`define AES_BLOCK_W 128

// AES-128 round count
`define AES_ROUNDS 10

// Credit flow control, input buffer depth and initial output credits
`define AES_IN_CREDITS 8
`define AES_OUT_CREDITS 4

// Chaining mode select in the command block
`define AES_MODE_BIT 0

`endif

//--- run_sim.sh
#!/bin/sh
# Build and run the aes_ctrl testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f aes_ctrl.f \
	--top-module aes_ctrl_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vaes_ctrl_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
	echo "Simulation reported a failure"
	exit 1
fi
if ! grep -q ">>> PASS" "$LOG"; then
	echo "Simulation ended without a verdict"
	exit 1
fi
exit 0

//--- src/aes_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "aes_ctrl_cfg.svh"

module aes_ctrl_fsm (
	input  wire                       clk,
	input  wire                       reset,
	input  wire                       blk_valid,
	input  wire aes_ctrl_pkg::block_t blk_data,
	input  wire                       blk_last,
	input  wire                       done,
	input  wire                       res_free,
	output logic                      blk_take,
	output logic                      start,
	output aes_ctrl_pkg::key_t        key,
	output aes_ctrl_pkg::chain_mode_t mode,
	output logic                      iv_load,
	output logic                      chain_update,
	output logic                      res_valid,
	output logic                      res_last
);

	aes_ctrl_pkg::ctrl_state_t state;
	logic                      busy;
	logic                      cur_last;

	// ====================================================================
	// Block acceptance and strobes

	always_comb begin
		case (state)
			aes_ctrl_pkg::ST_PAYLOAD:
				// Core idle and a free result slot
				blk_take = blk_valid && !busy && res_free;
			default:
				blk_take = blk_valid;
		endcase
	end

	assign start        = blk_take && (state == aes_ctrl_pkg::ST_PAYLOAD);
	assign iv_load      = blk_take && (state == aes_ctrl_pkg::ST_IV);
	assign res_valid    = done;
	assign res_last     = cur_last;
	assign chain_update = done && (mode == aes_ctrl_pkg::MODE_CBC);

	// ====================================================================
	// Message sequencing

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= aes_ctrl_pkg::ST_CMD;
			mode     <= aes_ctrl_pkg::MODE_ECB;
			busy     <= 1'b0;
			cur_last <= 1'b0;
		end else begin
			case (state)
				aes_ctrl_pkg::ST_CMD: begin
					if (blk_take) begin
						mode  <= aes_ctrl_pkg::chain_mode_t'(blk_data[`AES_MODE_BIT]);
						state <= aes_ctrl_pkg::ST_KEY;
					end
				end
				aes_ctrl_pkg::ST_KEY: begin
					if (blk_take)
						state <= (mode == aes_ctrl_pkg::MODE_CBC) ?
							aes_ctrl_pkg::ST_IV : aes_ctrl_pkg::ST_PAYLOAD;
				end
				aes_ctrl_pkg::ST_IV: begin
					// An IV with no data ends the message
					if (blk_take)
						state <= blk_last ? aes_ctrl_pkg::ST_CMD : aes_ctrl_pkg::ST_PAYLOAD;
				end
				default: begin
					if (start) begin
						busy     <= 1'b1;
						cur_last <= blk_last;
					end else if (done) begin
						busy <= 1'b0;
						// Wait for the final result before the next command
						if (cur_last)
							state <= aes_ctrl_pkg::ST_CMD;
					end
				end
			endcase
		end
	end

	// Cipher key
	always_ff @(posedge clk) begin
		if (blk_take && state == aes_ctrl_pkg::ST_KEY)
			key <= blk_data;
	end

endmodule

`default_nettype wire

//--- src/aes_ctrl_pkg.sv
`default_nettype none

`include "aes_ctrl_cfg.svh"

package aes_ctrl_pkg;

	typedef logic [`AES_WORD_W-1:0]  word_t;
	typedef logic [`AES_BLOCK_W-1:0] block_t;
	typedef logic [`AES_BLOCK_W-1:0] key_t;
	typedef logic [7:0]              byte_t;
	typedef logic [3:0]              round_t;

	typedef enum logic {
		MODE_ECB = 1'b0,
		MODE_CBC = 1'b1
	} chain_mode_t;

	typedef enum logic [1:0] {
		ST_CMD     = 2'd0,
		ST_KEY     = 2'd1,
		ST_IV      = 2'd2,
		ST_PAYLOAD = 2'd3
	} ctrl_state_t;

	// ====================================================================
	// FIPS-197 forward S-box

	// Entry 0 sits in the top byte
	localparam logic [2047:0] SBOX_TABLE = {
		128'h637c777bf26b6fc53001672bfed7ab76,
		128'hca82c97dfa5947f0add4a2af9ca472c0,
		128'hb7fd9326363ff7cc34a5e5f171d83115,
		128'h04c723c31896059a071280e2eb27b275,
		128'h09832c1a1b6e5aa0523bd6b329e32f84,
		128'h53d100ed20fcb15b6acbbe394a4c58cf,
		128'hd0efaafb434d338545f9027f503c9fa8,
		128'h51a3408f929d38f5bcb6da2110fff3d2,
		128'hcd0c13ec5f974417c4a77e3d645d1973,
		128'h60814fdc222a908846eeb814de5e0bdb,
		128'he0323a0a4906245cc2d3ac629195e479,
		128'he7c8376d8dd54ea96c56f4ea657aae08,
		128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
		128'h703eb5664803f60e613557b986c11d9e,
		128'he1f8981169d98e949b1e87e9ce5528df,
		128'h8ca1890dbfe6426841992d0fb054bb16
	};

	function automatic byte_t sbox(input byte_t x);
		int unsigned idx;
		idx = 255 - int'(x);
		return SBOX_TABLE[8 * idx +: 8];
	endfunction

endpackage

`default_nettype wire

//--- src/aes_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module aes_ctrl_top (
	input  wire                      clk,
	input  wire                      reset,
	input  wire                      in_valid,
	input  wire aes_ctrl_pkg::word_t in_data,
	input  wire                      in_last,
	output logic                     in_credit,
	output logic                     out_valid,
	output aes_ctrl_pkg::word_t      out_data,
	output logic                     out_last,
	input  wire                      out_credit
);

	// ====================================================================
	// Internal links

	// Packer to controller
	logic                      blk_valid;
	aes_ctrl_pkg::block_t      blk_data;
	logic                      blk_last;
	logic                      blk_take;

	// Controller to cipher and chaining
	logic                      start;
	aes_ctrl_pkg::key_t        key;
	aes_ctrl_pkg::chain_mode_t mode;
	aes_ctrl_pkg::block_t      core_in;
	logic                      iv_load;
	logic                      chain_update;

	// Cipher results and output side
	logic                      done;
	aes_ctrl_pkg::block_t      core_out;
	logic                      res_valid;
	logic                      res_last;
	logic                      res_free;

	// ====================================================================
	// Datapaths around the controller

	block_packer packer_i (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.in_last   (in_last),
		.blk_take  (blk_take),
		.in_credit (in_credit),
		.blk_valid (blk_valid),
		.blk_data  (blk_data),
		.blk_last  (blk_last)
	);

	aes_ctrl_fsm fsm_i (
		.clk          (clk),
		.reset        (reset),
		.blk_valid    (blk_valid),
		.blk_data     (blk_data),
		.blk_last     (blk_last),
		.done         (done),
		.res_free     (res_free),
		.blk_take     (blk_take),
		.start        (start),
		.key          (key),
		.mode         (mode),
		.iv_load      (iv_load),
		.chain_update (chain_update),
		.res_valid    (res_valid),
		.res_last     (res_last)
	);

	aes_enc_core core_i (
		.clk      (clk),
		.reset    (reset),
		.start    (start),
		.key      (key),
		.core_in  (core_in),
		.done     (done),
		.core_out (core_out)
	);

	cbc_chain chain_i (
		.clk          (clk),
		.reset        (reset),
		.iv_load      (iv_load),
		.chain_update (chain_update),
		.mode         (mode),
		.blk_data     (blk_data),
		.core_out     (core_out),
		.core_in      (core_in)
	);

	block_unpacker unpacker_i (
		.clk        (clk),
		.reset      (reset),
		.res_valid  (res_valid),
		.res_last   (res_last),
		.core_out   (core_out),
		.out_credit (out_credit),
		.res_free   (res_free),
		.out_valid  (out_valid),
		.out_data   (out_data),
		.out_last   (out_last)
	);

endmodule

`default_nettype wire

//--- src/aes_enc_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "aes_ctrl_cfg.svh"

module aes_enc_core (
	input  wire                       clk,
	input  wire                       reset,
	input  wire                       start,
	input  wire aes_ctrl_pkg::key_t   key,
	input  wire aes_ctrl_pkg::block_t core_in,
	output logic                      done,
	output aes_ctrl_pkg::block_t      core_out
);

	aes_ctrl_pkg::block_t st;
	aes_ctrl_pkg::key_t   rk;
	aes_ctrl_pkg::round_t round;
	aes_ctrl_pkg::byte_t  rcon;
	logic                 busy;

	aes_ctrl_pkg::byte_t  sub_b [16];
	aes_ctrl_pkg::block_t sr_blk;
	aes_ctrl_pkg::block_t mc_blk;
	aes_ctrl_pkg::key_t   rk_next;
	aes_ctrl_pkg::block_t st_next;
	logic                 last_round;

	// ====================================================================
	// GF(2^8) helpers

	function automatic aes_ctrl_pkg::byte_t xtime(input aes_ctrl_pkg::byte_t b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	function automatic aes_ctrl_pkg::word_t mix_column(input aes_ctrl_pkg::word_t col);
		aes_ctrl_pkg::byte_t a0;
		aes_ctrl_pkg::byte_t a1;
		aes_ctrl_pkg::byte_t a2;
		aes_ctrl_pkg::byte_t a3;
		a0 = col[31:24];
		a1 = col[23:16];
		a2 = col[15:8];
		a3 = col[7:0];
		return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
			a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
			a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
			xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
	endfunction

	// Next round key from the current one, on the fly
	function automatic aes_ctrl_pkg::key_t expand_key(input aes_ctrl_pkg::key_t k,
			input aes_ctrl_pkg::byte_t rc);
		aes_ctrl_pkg::word_t t;
		aes_ctrl_pkg::word_t w0;
		aes_ctrl_pkg::word_t w1;
		aes_ctrl_pkg::word_t w2;
		aes_ctrl_pkg::word_t w3;
		// RotWord then SubWord on the last word
		t = {aes_ctrl_pkg::sbox(k[23:16]), aes_ctrl_pkg::sbox(k[15:8]),
			aes_ctrl_pkg::sbox(k[7:0]), aes_ctrl_pkg::sbox(k[31:24])};
		t[31:24] = t[31:24] ^ rc;
		w0 = k[127:96] ^ t;
		w1 = k[95:64] ^ w0;
		w2 = k[63:32] ^ w1;
		w3 = k[31:0] ^ w2;
		return {w0, w1, w2, w3};
	endfunction

	// ====================================================================
	// One round of encryption

	always_comb begin
		for (int i = 0; i < 16; i++)
			sub_b[i] = aes_ctrl_pkg::sbox(st[127 - 8 * i -: 8]);
		// Row r rotates left by r columns
		for (int c = 0; c < 4; c++)
			for (int r = 0; r < 4; r++)
				sr_blk[127 - 8 * (4 * c + r) -: 8] = sub_b[4 * ((c + r) % 4) + r];
		for (int c = 0; c < 4; c++)
			mc_blk[127 - 32 * c -: 32] = mix_column(sr_blk[127 - 32 * c -: 32]);
		rk_next    = expand_key(rk, rcon);
		last_round = (round == aes_ctrl_pkg::round_t'(`AES_ROUNDS));
		// No MixColumns in the final round
		st_next    = (last_round ? sr_blk : mc_blk) ^ rk_next;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy  <= 1'b0;
			done  <= 1'b0;
			round <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy  <= 1'b1;
				round <= aes_ctrl_pkg::round_t'(1);
			end else if (busy) begin
				if (last_round) begin
					busy <= 1'b0;
					done <= 1'b1;
				end else begin
					round <= round + 1'b1;
				end
			end
		end
	end

	// Initial AddRoundKey on load
	always_ff @(posedge clk) begin
		if (start) begin
			st   <= core_in ^ key;
			rk   <= key;
			rcon <= 8'h01;
		end else if (busy) begin
			st   <= st_next;
			rk   <= rk_next;
			rcon <= xtime(rcon);
		end
	end

	assign core_out = st;

endmodule

`default_nettype wire

//--- src/block_packer.sv
`timescale 1ns/1ps
`default_nettype none

`include "aes_ctrl_cfg.svh"

module block_packer (
	input  wire                      clk,
	input  wire                      reset,
	input  wire                      in_valid,
	input  wire aes_ctrl_pkg::word_t in_data,
	input  wire                      in_last,
	input  wire                      blk_take,
	output logic                     in_credit,
	output logic                     blk_valid,
	output aes_ctrl_pkg::block_t     blk_data,
	output logic                     blk_last
);

	localparam int DEPTH = `AES_IN_CREDITS;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	aes_ctrl_pkg::word_t mem_data [DEPTH];
	logic                mem_last [DEPTH];
	logic [PTR_W-1:0]    wr_ptr;
	logic [PTR_W-1:0]    rd_ptr;
	logic [CNT_W-1:0]    count;
	logic [2:0]          asm_cnt;
	logic                move;

	assign blk_valid = (asm_cnt == 3'd4);

	// A word moves on when the assembly register has room or is emptied now
	assign move = (count != '0) && (!blk_valid || blk_take);

	// Word buffer, sender never writes without a credit
	always_ff @(posedge clk) begin
		if (in_valid) begin
			mem_data[wr_ptr] <= in_data;
			mem_last[wr_ptr] <= in_last;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			in_credit <= 1'b0;
		end else begin
			if (in_valid)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (move)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (in_valid && !move)
				count <= count + 1'b1;
			else if (!in_valid && move)
				count <= count - 1'b1;
			// One credit back per word leaving the buffer
			in_credit <= move;
		end
	end

	// Assembly word count
	always_ff @(posedge clk) begin
		if (reset)
			asm_cnt <= '0;
		else if (move && blk_take)
			asm_cnt <= 3'd1;
		else if (move)
			asm_cnt <= asm_cnt + 1'b1;
		else if (blk_take)
			asm_cnt <= '0;
	end

	// First word ends up most significant
	always_ff @(posedge clk) begin
		if (move) begin
			blk_data <= {blk_data[`AES_BLOCK_W-`AES_WORD_W-1:0], mem_data[rd_ptr]};
			blk_last <= mem_last[rd_ptr];
		end
	end

endmodule

`default_nettype wire

//--- src/block_unpacker.sv
`timescale 1ns/1ps
`default_nettype none

`include "aes_ctrl_cfg.svh"

module block_unpacker (
	input  wire                       clk,
	input  wire                       reset,
	input  wire                       res_valid,
	input  wire                       res_last,
	input  wire aes_ctrl_pkg::block_t core_out,
	input  wire                       out_credit,
	output logic                      res_free,
	output logic                      out_valid,
	output aes_ctrl_pkg::word_t       out_data,
	output logic                      out_last
);

	localparam int CRD_W = $clog2(`AES_OUT_CREDITS + 1);

	aes_ctrl_pkg::block_t hold_data;
	logic                 hold_last;
	logic                 hold_full;
	aes_ctrl_pkg::block_t sh_data;
	logic                 sh_last;
	logic [2:0]           sh_left;
	logic [CRD_W-1:0]     credits;
	logic                 sh_free;

	assign out_valid = (sh_left != 3'd0) && (credits != '0);
	assign out_data  = sh_data[`AES_BLOCK_W-1 -: `AES_WORD_W];
	assign out_last  = out_valid && sh_last && (sh_left == 3'd1);
	assign res_free  = !hold_full;

	// Serialiser empty, or sending its last word now
	assign sh_free = (sh_left == 3'd0) || (out_valid && sh_left == 3'd1);

	always_ff @(posedge clk) begin
		if (reset) begin
			sh_left   <= '0;
			hold_full <= 1'b0;
		end else begin
			if (sh_free && (hold_full || res_valid))
				sh_left <= 3'd4;
			else if (out_valid)
				sh_left <= sh_left - 1'b1;
			if (sh_free)
				hold_full <= hold_full && res_valid;
			else if (res_valid)
				hold_full <= 1'b1;
		end
	end

	// Held block goes first, a new result bypasses an empty holder
	always_ff @(posedge clk) begin
		if (sh_free && hold_full) begin
			sh_data <= hold_data;
			sh_last <= hold_last;
		end else if (sh_free && res_valid) begin
			sh_data <= core_out;
			sh_last <= res_last;
		end else if (out_valid) begin
			sh_data <= sh_data << `AES_WORD_W;
		end
		if (res_valid) begin
			hold_data <= core_out;
			hold_last <= res_last;
		end
	end

	// Output credits
	always_ff @(posedge clk) begin
		if (reset)
			credits <= CRD_W'(`AES_OUT_CREDITS);
		else if (out_valid && !out_credit)
			credits <= credits - 1'b1;
		else if (!out_valid && out_credit)
			credits <= credits + 1'b1;
	end

endmodule

`default_nettype wire

//--- src/cbc_chain.sv
`timescale 1ns/1ps
`default_nettype none

module cbc_chain (
	input  wire                            clk,
	input  wire                            reset,
	input  wire                            iv_load,
	input  wire                            chain_update,
	input  wire aes_ctrl_pkg::chain_mode_t mode,
	input  wire aes_ctrl_pkg::block_t      blk_data,
	input  wire aes_ctrl_pkg::block_t      core_out,
	output aes_ctrl_pkg::block_t           core_in
);

	aes_ctrl_pkg::block_t chain;

	// IV first, then each ciphertext block
	always_ff @(posedge clk) begin
		if (reset)
			chain <= '0;
		else if (iv_load)
			chain <= blk_data;
		else if (chain_update)
			chain <= core_out;
	end

	// Plaintext whitening in CBC only
	assign core_in = (mode == aes_ctrl_pkg::MODE_CBC) ? (blk_data ^ chain) : blk_data;

endmodule

`default_nettype wire

//--- verification/aes_ctrl_sva.sv
`timescale 1ns/1ps
`default_nettype none

`include "aes_ctrl_cfg.svh"

module aes_ctrl_sva (
	input wire clk,
	input wire reset,
	input wire in_valid,
	input wire in_last,
	input wire out_valid,
	input wire out_last,
	input wire out_credit,
	input wire start,
	input wire done
);

	logic [3:0] out_crd;
	logic [1:0] in_pos;
	logic [1:0] out_pos;

	// Output credits as seen on the bus
	always_ff @(posedge clk) begin
		if (reset)
			out_crd <= 4'(`AES_OUT_CREDITS);
		else if (out_valid && !out_credit)
			out_crd <= out_crd - 1'b1;
		else if (!out_valid && out_credit)
			out_crd <= out_crd + 1'b1;
	end

	// Word position inside the current input block
	always_ff @(posedge clk) begin
		if (reset)
			in_pos <= '0;
		else if (in_valid)
			in_pos <= in_pos + 1'b1;
	end

	// Word position inside the current output block
	always_ff @(posedge clk) begin
		if (reset)
			out_pos <= '0;
		else if (out_valid)
			out_pos <= out_pos + 1'b1;
	end

	a_out_credit: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> out_crd != '0)
		else $error("out_valid with no output credit left");

	a_in_last: assert property (@(posedge clk) disable iff (reset)
		(in_valid && in_last) |-> in_pos == 2'd3)
		else $error("in_last on a word other than the fourth of a block");

	// Load cycle plus ten rounds
	a_done_after_start: assert property (@(posedge clk) disable iff (reset)
		start |-> ##11 done)
		else $error("done missing 11 cycles after start");

	a_done_has_start: assert property (@(posedge clk) disable iff (reset)
		done |-> $past(start, 11))
		else $error("done without a start 11 cycles earlier");

	a_out_last: assert property (@(posedge clk) disable iff (reset)
		out_last |-> out_valid && out_pos == 2'd3)
		else $error("out_last without out_valid or off the fourth word of a block");

endmodule

`default_nettype wire

//--- verification/aes_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "aes_ctrl_cfg.svh"

module aes_ctrl_tb;

	// Blocks per message: command, key, optional IV, data
	localparam int TOTAL_BLOCKS = (2 + 1) + (2 + 5) + (2 + 1 + 6)
		+ 2 * ((2 + 3) + (2 + 1 + 3)) + (2 + 6) + (2 + 1 + 4);

	localparam aes_ctrl_pkg::key_t   FIPS_KEY = 128'h2b7e151628aed2a6abf7158809cf4f3c;
	localparam aes_ctrl_pkg::block_t FIPS_PT  = 128'h3243f6a8885a308d313198a2e0370734;
	localparam aes_ctrl_pkg::block_t FIPS_CT  = 128'h3925841d02dc09fbdc118597196a0b32;

	logic                clk = 1'b0;
	logic                reset;
	logic                in_valid;
	aes_ctrl_pkg::word_t in_data;
	logic                in_last;
	logic                in_credit;
	logic                out_valid;
	aes_ctrl_pkg::word_t out_data;
	logic                out_last;
	logic                out_credit;

	int                   in_credits;
	int                   owed;
	int                   out_words;
	int                   pause_lo;
	int                   pause_hi;
	int                   gap_hi;
	aes_ctrl_pkg::word_t  exp_words [$];
	logic                 exp_lasts [$];
	aes_ctrl_pkg::block_t msg_blocks [$];

	aes_ctrl_top dut_i (
		.clk        (clk),
		.reset      (reset),
		.in_valid   (in_valid),
		.in_data    (in_data),
		.in_last    (in_last),
		.in_credit  (in_credit),
		.out_valid  (out_valid),
		.out_data   (out_data),
		.out_last   (out_last),
		.out_credit (out_credit)
	);

	bind aes_ctrl_top aes_ctrl_sva sva_i (
		.clk        (clk),
		.reset      (reset),
		.in_valid   (in_valid),
		.in_last    (in_last),
		.out_valid  (out_valid),
		.out_last   (out_last),
		.out_credit (out_credit),
		.start      (start),
		.done       (done)
	);

	always #5 clk = ~clk;

	// ====================================================================
	// Reference AES-128

	function automatic aes_ctrl_pkg::byte_t gmul2(input aes_ctrl_pkg::byte_t b);
		return b[7] ? ((b << 1) ^ 8'h1b) : (b << 1);
	endfunction

	function automatic aes_ctrl_pkg::block_t ref_aes_enc(input aes_ctrl_pkg::key_t k,
			input aes_ctrl_pkg::block_t pt);
		aes_ctrl_pkg::word_t  w [44];
		aes_ctrl_pkg::byte_t  s [16];
		aes_ctrl_pkg::byte_t  t [16];
		aes_ctrl_pkg::word_t  tmp;
		aes_ctrl_pkg::byte_t  rc;
		aes_ctrl_pkg::byte_t  a0;
		aes_ctrl_pkg::byte_t  a1;
		aes_ctrl_pkg::byte_t  a2;
		aes_ctrl_pkg::byte_t  a3;
		aes_ctrl_pkg::block_t res;
		// Full key schedule up front
		rc = 8'h01;
		for (int i = 0; i < 4; i++)
			w[i] = k[127 - 32 * i -: 32];
		for (int i = 4; i < 44; i++) begin
			tmp = w[i - 1];
			if (i % 4 == 0) begin
				tmp = {aes_ctrl_pkg::sbox(tmp[23:16]), aes_ctrl_pkg::sbox(tmp[15:8]),
					aes_ctrl_pkg::sbox(tmp[7:0]), aes_ctrl_pkg::sbox(tmp[31:24])};
				tmp[31:24] = tmp[31:24] ^ rc;
				rc = gmul2(rc);
			end
			w[i] = w[i - 4] ^ tmp;
		end
		// Byte i is row i%4 of column i/4
		for (int i = 0; i < 16; i++)
			s[i] = pt[127 - 8 * i -: 8] ^ w[i / 4][31 - 8 * (i % 4) -: 8];
		for (int r = 1; r <= `AES_ROUNDS; r++) begin
			for (int c = 0; c < 4; c++)
				for (int j = 0; j < 4; j++)
					t[4 * c + j] = aes_ctrl_pkg::sbox(s[4 * ((c + j) % 4) + j]);
			for (int c = 0; c < 4; c++) begin
				a0 = t[4 * c];
				a1 = t[4 * c + 1];
				a2 = t[4 * c + 2];
				a3 = t[4 * c + 3];
				if (r == `AES_ROUNDS) begin
					s[4 * c]     = a0;
					s[4 * c + 1] = a1;
					s[4 * c + 2] = a2;
					s[4 * c + 3] = a3;
				end else begin
					s[4 * c]     = gmul2(a0) ^ gmul2(a1) ^ a1 ^ a2 ^ a3;
					s[4 * c + 1] = a0 ^ gmul2(a1) ^ gmul2(a2) ^ a2 ^ a3;
					s[4 * c + 2] = a0 ^ a1 ^ gmul2(a2) ^ gmul2(a3) ^ a3;
					s[4 * c + 3] = gmul2(a0) ^ a0 ^ a1 ^ a2 ^ gmul2(a3);
				end
			end
			for (int i = 0; i < 16; i++)
				s[i] = s[i] ^ w[4 * r + i / 4][31 - 8 * (i % 4) -: 8];
		end
		for (int i = 0; i < 16; i++)
			res[127 - 8 * i -: 8] = s[i];
		return res;
	endfunction

	function automatic aes_ctrl_pkg::block_t random_block();
		return {$urandom(), $urandom(), $urandom(), $urandom()};
	endfunction

	// ====================================================================
	// Checks

	task automatic fail_now(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		$display(">>> FAIL");
		$fatal(1, "testbench stopped on error");
	endtask

	task automatic check_word(input aes_ctrl_pkg::word_t got, input aes_ctrl_pkg::word_t exp,
			input string what);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s expected %h got %h", $time, what, exp, got);
			$display(">>> FAIL");
			$fatal(1, "word mismatch");
		end
	endtask

	task automatic check_last(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s expected %b got %b", $time, what, exp, got);
			$display(">>> FAIL");
			$fatal(1, "flag mismatch");
		end
	endtask

	task automatic check_block(input aes_ctrl_pkg::block_t got, input aes_ctrl_pkg::block_t exp,
			input string what);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s expected %h got %h", $time, what, exp, got);
			$display(">>> FAIL");
			$fatal(1, "block mismatch");
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			$display("FAILED at %0t ns: %s expected %0d got %0d", $time, what, exp, got);
			$display(">>> FAIL");
			$fatal(1, "count mismatch");
		end
	endtask

	// ====================================================================
	// Stimulus, called 1 ns after a rising edge

	task automatic send_word(input aes_ctrl_pkg::word_t data, input logic last);
		repeat ($urandom_range(gap_hi, 0)) begin
			@(posedge clk);
			#1;
		end
		while (in_credits == 0) begin
			@(posedge clk);
			#1;
		end
		in_valid = 1'b1;
		in_data  = data;
		in_last  = last;
		in_credits--;
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		in_last  = 1'b0;
	endtask

	task automatic send_block(input aes_ctrl_pkg::block_t b, input logic last);
		for (int i = 0; i < 4; i++)
			send_word(b[127 - 32 * i -: 32], last && (i == 3));
	endtask

	task automatic add_expected(input aes_ctrl_pkg::block_t ct, input logic last);
		for (int i = 0; i < 4; i++) begin
			exp_words.push_back(ct[127 - 32 * i -: 32]);
			exp_lasts.push_back(last && (i == 3));
		end
	endtask

	task automatic fill_random(input int n);
		msg_blocks.delete();
		repeat (n)
			msg_blocks.push_back(random_block());
	endtask

	// Mode model, then command, key and payload from msg_blocks
	task automatic send_message(input aes_ctrl_pkg::chain_mode_t mode,
			input aes_ctrl_pkg::key_t k);
		aes_ctrl_pkg::block_t cmd;
		aes_ctrl_pkg::block_t chain;
		aes_ctrl_pkg::block_t ct;
		int                   first;
		first = (mode == aes_ctrl_pkg::MODE_CBC) ? 1 : 0;
		chain = msg_blocks[0];
		for (int i = first; i < msg_blocks.size(); i++) begin
			if (mode == aes_ctrl_pkg::MODE_CBC) begin
				ct    = ref_aes_enc(k, msg_blocks[i] ^ chain);
				chain = ct;
			end else begin
				ct = ref_aes_enc(k, msg_blocks[i]);
			end
			add_expected(ct, i == msg_blocks.size() - 1);
		end
		// Other command bits are don't care
		cmd = random_block();
		cmd[`AES_MODE_BIT] = (mode == aes_ctrl_pkg::MODE_CBC);
		send_block(cmd, 1'b0);
		send_block(k, 1'b0);
		for (int i = 0; i < msg_blocks.size(); i++)
			send_block(msg_blocks[i], i == msg_blocks.size() - 1);
	endtask

	task automatic wait_idle();
		while (exp_words.size() != 0) begin
			@(posedge clk);
			#1;
		end
		repeat (4) @(posedge clk);
		#1;
		check_count(in_credits, `AES_IN_CREDITS, "input credits when idle");
	endtask

	// ====================================================================
	// Credit tracking, output sink and compare

	always @(negedge clk) begin
		if (!reset && in_credit) begin
			in_credits++;
			if (in_credits > `AES_IN_CREDITS)
				fail_now("input credit count rose above the buffer depth");
		end
	end

	always @(negedge clk) begin : compare_outputs
		aes_ctrl_pkg::word_t exp_w;
		logic                exp_l;
		if (!reset && out_valid) begin
			if (exp_words.size() == 0) begin
				fail_now("output word appeared with no result expected");
			end else begin
				exp_w = exp_words.pop_front();
				exp_l = exp_lasts.pop_front();
				check_word(out_data, exp_w, $sformatf("out_data of word %0d", out_words));
				check_last(out_last, exp_l, $sformatf("out_last of word %0d", out_words));
				out_words++;
				owed++;
			end
		end
	end

	// One credit back per received word, after a random pause
	initial begin : return_credits
		int pause;
		out_credit = 1'b0;
		pause      = 0;
		forever begin
			@(posedge clk);
			#1;
			out_credit = 1'b0;
			if (owed > 0) begin
				if (pause > 0) begin
					pause--;
				end else begin
					out_credit = 1'b1;
					owed--;
					pause = $urandom_range(pause_hi, pause_lo);
				end
			end
		end
	end

	initial begin : watchdog
		repeat (TOTAL_BLOCKS * 200) @(posedge clk);
		$display("Timeout: no verdict after %0d cycles", TOTAL_BLOCKS * 200);
		$display(">>> FAIL");
		$fatal(1, "watchdog expired");
	end

	// ====================================================================
	// Test sequence

	initial begin : main
		aes_ctrl_pkg::chain_mode_t m;
		void'($urandom(63));
		reset      = 1'b1;
		in_valid   = 1'b0;
		in_data    = '0;
		in_last    = 1'b0;
		in_credits = `AES_IN_CREDITS;
		owed       = 0;
		out_words  = 0;
		pause_lo   = 0;
		pause_hi   = 3;
		gap_hi     = 2;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		check_last(in_credit, 1'b0, "in_credit after reset");
		check_last(out_valid, 1'b0, "out_valid after reset");
		check_last(out_last, 1'b0, "out_last after reset");
		check_block(dut_i.chain_i.chain, '0, "chaining register after reset");

		// FIPS-197 Appendix B vector guards the S-box table
		check_block(ref_aes_enc(FIPS_KEY, FIPS_PT), FIPS_CT, "reference AES on FIPS-197");
		msg_blocks.delete();
		msg_blocks.push_back(FIPS_PT);
		send_message(aes_ctrl_pkg::MODE_ECB, FIPS_KEY);
		wait_idle();

		fill_random(5);
		send_message(aes_ctrl_pkg::MODE_ECB, random_block());
		wait_idle();

		// IV plus six data blocks
		fill_random(7);
		send_message(aes_ctrl_pkg::MODE_CBC, random_block());
		wait_idle();

		// Back to back, new key each time
		gap_hi = 0;
		for (int n = 0; n < 4; n++) begin
			m = (n % 2 == 1) ? aes_ctrl_pkg::MODE_CBC : aes_ctrl_pkg::MODE_ECB;
			fill_random((m == aes_ctrl_pkg::MODE_CBC) ? 4 : 3);
			send_message(m, random_block());
		end
		wait_idle();

		// Sink holds credits for long stretches
		pause_lo = 20;
		pause_hi = 50;
		fill_random(6);
		send_message(aes_ctrl_pkg::MODE_ECB, random_block());
		fill_random(5);
		send_message(aes_ctrl_pkg::MODE_CBC, random_block());
		wait_idle();

		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire
